/* logic/phy_write_pkg.sv */
package phy_write_pkg;

	// Memory side of the interface
	localparam int mem_write_dqs_width = 2; // One DQS group per byte lane
	localparam int mem_dq_width = 16;

	// Half-rate AFI word carries two memory cycles
	// The high half is the first memory cycle and the low half the second
	localparam int afi_dqs_width = 2 * mem_write_dqs_width;

	// Two edges per memory cycle and two memory cycles per AFI word
	localparam int afi_data_width = 4 * mem_dq_width;

	localparam int afi_data_mask_width = afi_data_width / 8; // One mask bit per byte

	// Configuration register map
	localparam logic cfg_addr_oct = 1'b0; // force_oct_off, one bit per AFI DQS bit
	localparam logic cfg_addr_preamble = 1'b1; // preamble_en in bit 0

endpackage

/* logic/phy_write_config.sv */
`timescale 1ns/10ps

module phy_write_config (
	input  logic pll_afi_clk,
	input  logic reset,

	// Host configuration port, four-phase
	input  logic cfg_req,
	input  logic cfg_addr,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] cfg_wdata,
	output logic cfg_ack,

	// Steering of the write path
	output logic [phy_write_pkg::afi_dqs_width-1:0] force_oct_off,
	output logic preamble_en
);

	logic cfg_write;
	logic cfg_release; // Request seen low while acknowledged

	// A write takes effect on the same edge that raises the ack
	assign cfg_write = cfg_req && !cfg_ack;

	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			force_oct_off <= '0; // Termination follows DQS by default
			preamble_en <= 1'b1;
		end
		else if (cfg_write)
		begin
			if (cfg_addr == phy_write_pkg::cfg_addr_oct)
				force_oct_off <= cfg_wdata;
			else if (cfg_addr == phy_write_pkg::cfg_addr_preamble)
				preamble_en <= cfg_wdata[0];
		end
	end

	// Ack falls on the edge after the one that first sees the request low
	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			cfg_ack <= 1'b0;
			cfg_release <= 1'b0;
		end
		else if (cfg_release)
		begin
			cfg_ack <= 1'b0;
			cfg_release <= 1'b0;
		end
		else if (cfg_write)
		begin
			cfg_ack <= 1'b1;
		end
		else if (cfg_ack && !cfg_req)
		begin
			cfg_release <= 1'b1;
		end
	end

endmodule

/* logic/afi_write_sequencer.sv */
`timescale 1ns/10ps

module afi_write_sequencer (
	input  logic pll_afi_clk,
	input  logic reset,

	// Host write port, four-phase
	input  logic wr_req,
	input  logic [phy_write_pkg::afi_data_width-1:0] wr_data,
	input  logic [phy_write_pkg::afi_data_mask_width-1:0] wr_mask,
	output logic wr_ack,

	input  logic preamble_en,

	// AFI write signals toward the datapath
	output logic [phy_write_pkg::afi_dqs_width-1:0] afi_dqs_en,
	output logic [phy_write_pkg::afi_dqs_width-1:0] afi_wdata_valid,
	output logic [phy_write_pkg::afi_data_width-1:0] afi_wdata,
	output logic [phy_write_pkg::afi_data_mask_width-1:0] afi_dm
);

	typedef enum logic [1:0]
	{
		st_idle,
		st_preamble,
		st_data,
		st_release
	} state_t;

	state_t state;
	logic accept;

	// A new beat is only taken while the previous ack has cleared
	assign accept = (state == st_idle) && wr_req && !wr_ack;

	// Beat is captured at acceptance and held until the next one
	always_ff @(posedge pll_afi_clk)
	begin
		if (accept)
		begin
			afi_wdata <= wr_data;
			afi_dm <= wr_mask;
		end
	end

	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			wr_ack <= 1'b0;
			afi_dqs_en <= '0;
			afi_wdata_valid <= '0;
		end
		else
		begin
			// Strobes are single-cycle unless a state below asserts them
			afi_dqs_en <= '0;
			afi_wdata_valid <= '0;

			case (state)
			st_idle:
			begin
				if (wr_ack)
					wr_ack <= 1'b0; // Release was seen on the previous edge
				if (accept)
					state <= st_preamble;
			end
			st_preamble:
			begin
				// Without a preamble this cycle still passes, keeping the data latency fixed
				if (preamble_en)
					afi_dqs_en <= '1;
				state <= st_data;
			end
			st_data:
			begin
				afi_dqs_en <= '1;
				afi_wdata_valid <= '1;
				wr_ack <= 1'b1;
				state <= st_release;
			end
			st_release:
			begin
				if (!wr_req)
					state <= st_idle; // A held request issues nothing more
			end
			default:
			begin
				state <= st_idle;
			end
			endcase
		end
	end

endmodule

/* logic/phy_write_datapath.sv */
`timescale 1ns/10ps

module phy_write_datapath #(
	parameter int num_write_path_flop_stages = 2
) (
	input  logic pll_afi_clk,
	input  logic reset,

	input  logic [phy_write_pkg::afi_dqs_width-1:0] force_oct_off,

	// AFI write signals from the sequencer
	input  logic [phy_write_pkg::afi_dqs_width-1:0] afi_dqs_en,
	input  logic [phy_write_pkg::afi_data_width-1:0] afi_wdata,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] afi_wdata_valid,
	input  logic [phy_write_pkg::afi_data_mask_width-1:0] afi_dm,

	// Toward the DDIO output registers
	output logic [phy_write_pkg::afi_data_width-1:0] phy_ddio_dq,
	output logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_dqs_en,
	output logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_wrdata_en,
	output logic [phy_write_pkg::afi_data_mask_width-1:0] phy_ddio_wrdata_mask,
	output logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_oct_ena
);

	localparam int dqs_w = phy_write_pkg::afi_dqs_width;
	localparam int grp_w = phy_write_pkg::mem_write_dqs_width;
	localparam int pipe_width = phy_write_pkg::afi_data_width
		+ phy_write_pkg::afi_data_mask_width + 2 * dqs_w;

	logic [pipe_width-1:0] pipe_in;
	logic [pipe_width-1:0] pipe_out;
	logic [grp_w-1:0] dqs_en_hi_r; // High half of the output DQS enable, one cycle late
	logic [dqs_w-1:0] oct_ena;

	// All write signals travel through one chain so they stay aligned
	assign pipe_in = {afi_wdata, afi_dm, afi_wdata_valid, afi_dqs_en};

	generate
		if (num_write_path_flop_stages == 0)
		begin : no_stage_gen
			assign pipe_out = pipe_in;
		end
		else
		begin : stage_gen
			logic [pipe_width-1:0] pipe_r [num_write_path_flop_stages];

			always_ff @(posedge pll_afi_clk)
			begin
				if (reset)
				begin
					for (int i = 0; i < num_write_path_flop_stages; i++)
						pipe_r[i] <= '0;
				end
				else
				begin
					pipe_r[0] <= pipe_in;
					for (int i = 1; i < num_write_path_flop_stages; i++)
						pipe_r[i] <= pipe_r[i-1];
				end
			end

			assign pipe_out = pipe_r[num_write_path_flop_stages-1];
		end
	endgenerate

	assign {phy_ddio_dq, phy_ddio_wrdata_mask, phy_ddio_wrdata_en, phy_ddio_dqs_en} = pipe_out;

	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
			dqs_en_hi_r <= '0;
		else
			dqs_en_hi_r <= phy_ddio_dqs_en[dqs_w-1:grp_w];
	end

	// Termination is off while DQS drives the bus
	assign oct_ena[dqs_w-1:grp_w] = ~phy_ddio_dqs_en[dqs_w-1:grp_w];

	// The second memory cycle keeps it off one cycle longer to cover the postamble
	assign oct_ena[grp_w-1:0] = ~(phy_ddio_dqs_en[dqs_w-1:grp_w] | dqs_en_hi_r);

	assign phy_ddio_oct_ena = oct_ena & ~force_oct_off;

endmodule

/* logic/phy_write_top.sv */
`timescale 1ns/10ps

module phy_write_top #(
	parameter int num_write_path_flop_stages = 2 // Supported range is 0 to 3
) (
	input  logic pll_afi_clk,
	input  logic reset,

	// Host write port
	input  logic wr_req,
	input  logic [phy_write_pkg::afi_data_width-1:0] wr_data,
	input  logic [phy_write_pkg::afi_data_mask_width-1:0] wr_mask,
	output logic wr_ack,

	// Host configuration port
	input  logic cfg_req,
	input  logic cfg_addr,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] cfg_wdata,
	output logic cfg_ack,

	// DDIO side
	output logic [phy_write_pkg::afi_data_width-1:0] phy_ddio_dq,
	output logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_dqs_en,
	output logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_wrdata_en,
	output logic [phy_write_pkg::afi_data_mask_width-1:0] phy_ddio_wrdata_mask,
	output logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_oct_ena
);

	logic [phy_write_pkg::afi_dqs_width-1:0] force_oct_off;
	logic preamble_en;

	logic [phy_write_pkg::afi_dqs_width-1:0] afi_dqs_en;
	logic [phy_write_pkg::afi_dqs_width-1:0] afi_wdata_valid;
	logic [phy_write_pkg::afi_data_width-1:0] afi_wdata;
	logic [phy_write_pkg::afi_data_mask_width-1:0] afi_dm;

	phy_write_config config_inst (
		.pll_afi_clk   (pll_afi_clk),
		.reset         (reset),
		.cfg_req       (cfg_req),
		.cfg_addr      (cfg_addr),
		.cfg_wdata     (cfg_wdata),
		.cfg_ack       (cfg_ack),
		.force_oct_off (force_oct_off),
		.preamble_en   (preamble_en)
	);

	afi_write_sequencer sequencer_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset           (reset),
		.wr_req          (wr_req),
		.wr_data         (wr_data),
		.wr_mask         (wr_mask),
		.wr_ack          (wr_ack),
		.preamble_en     (preamble_en),
		.afi_dqs_en      (afi_dqs_en),
		.afi_wdata_valid (afi_wdata_valid),
		.afi_wdata       (afi_wdata),
		.afi_dm          (afi_dm)
	);

	phy_write_datapath #(
		.num_write_path_flop_stages (num_write_path_flop_stages)
	) datapath_inst (
		.pll_afi_clk          (pll_afi_clk),
		.reset                (reset),
		.force_oct_off        (force_oct_off),
		.afi_dqs_en           (afi_dqs_en),
		.afi_wdata            (afi_wdata),
		.afi_wdata_valid      (afi_wdata_valid),
		.afi_dm               (afi_dm),
		.phy_ddio_dq          (phy_ddio_dq),
		.phy_ddio_dqs_en      (phy_ddio_dqs_en),
		.phy_ddio_wrdata_en   (phy_ddio_wrdata_en),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_oct_ena     (phy_ddio_oct_ena)
	);

endmodule

/* test/phy_write_sva.sv */
`timescale 1ns/10ps

module phy_write_sva #(
	parameter int num_write_path_flop_stages = 2
) (
	input  logic pll_afi_clk,
	input  logic reset,
	input  logic wr_req,
	input  logic wr_ack,
	input  logic cfg_req,
	input  logic cfg_addr,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] cfg_wdata,
	input  logic cfg_ack,
	input  logic preamble_en,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] force_oct_off,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_dqs_en,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_wrdata_en,
	input  logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_oct_ena
);

	localparam int grp_w = phy_write_pkg::mem_write_dqs_width;

	int fail_count = 0; // Polled by the testbench
	logic write_seen;
	logic [grp_w-1:0] dqs_hi;
	logic [grp_w-1:0] dqs_hi_d;
	logic [phy_write_pkg::afi_dqs_width-1:0] oct_expected;

	assign dqs_hi = phy_ddio_dqs_en[phy_write_pkg::afi_dqs_width-1:grp_w];
	assign oct_expected = {~dqs_hi, ~(dqs_hi | dqs_hi_d)} & ~force_oct_off;

	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			write_seen <= 1'b0;
			dqs_hi_d <= '0;
		end
		else
		begin
			write_seen <= write_seen | wr_req;
			dqs_hi_d <= dqs_hi; // First memory cycle of the previous AFI word
		end
	end

	task automatic record_failure(input string msg);
		$error("Error at %0t ns: %s", $time, msg);
		fail_count++;
	endtask

	assert property (@(posedge pll_afi_clk) disable iff (reset) !write_seen |->
		(phy_ddio_wrdata_en == '0 && phy_ddio_dqs_en == '0 && phy_ddio_oct_ena == '1))
		else record_failure("DDIO outputs not idle before the first write");
	assert property (@(posedge pll_afi_clk) disable iff (reset)
		$rose(wr_ack) |-> ##num_write_path_flop_stages (phy_ddio_wrdata_en == '1))
		else record_failure("write enable latency wrong");
	assert property (@(posedge pll_afi_clk) disable iff (reset) phy_ddio_wrdata_en != '0 |->
		(phy_ddio_wrdata_en == '1 && phy_ddio_dqs_en == '1) ##1 (phy_ddio_wrdata_en == '0))
		else record_failure("write enable pulse malformed or DQS off during data");

	// DQS outside a data cycle is only the preamble right before it
	assert property (@(posedge pll_afi_clk) disable iff (reset)
		(phy_ddio_dqs_en != '0 && phy_ddio_wrdata_en == '0) |->
		(phy_ddio_dqs_en == '1) ##1 (phy_ddio_wrdata_en == '1))
		else record_failure("DQS enable outside preamble and data");
	assert property (@(posedge pll_afi_clk) disable iff (reset)
		phy_ddio_wrdata_en != '0 |-> $past(phy_ddio_dqs_en[0]) == preamble_en)
		else record_failure("preamble does not follow preamble_en");
	assert property (@(posedge pll_afi_clk) disable iff (reset)
		phy_ddio_oct_ena == oct_expected)
		else record_failure("termination enable wrong");

	// A register write lands on the edge that raises the ack
	assert property (@(posedge pll_afi_clk) disable iff (reset)
		$rose(cfg_ack) && $past(cfg_addr) == phy_write_pkg::cfg_addr_oct |->
		force_oct_off == $past(cfg_wdata))
		else record_failure("force_oct_off does not hold the written mask");
	assert property (@(posedge pll_afi_clk) disable iff (reset)
		$rose(cfg_ack) && $past(cfg_addr) == phy_write_pkg::cfg_addr_preamble |->
		preamble_en == $past(cfg_wdata[0]))
		else record_failure("preamble_en does not hold the written bit");

	assert property (@(posedge pll_afi_clk) disable iff (reset) $rose(wr_ack) |-> $past(wr_req))
		else record_failure("wr_ack rose without wr_req");
	assert property (@(posedge pll_afi_clk) disable iff (reset) $fell(wr_ack) |-> !$past(wr_req))
		else record_failure("wr_ack fell while wr_req high");
	assert property (@(posedge pll_afi_clk) disable iff (reset) $fell(wr_req) |-> ##2 !wr_ack)
		else record_failure("wr_ack late to fall");
	assert property (@(posedge pll_afi_clk) disable iff (reset) $rose(cfg_ack) |-> $past(cfg_req))
		else record_failure("cfg_ack rose without cfg_req");
	assert property (@(posedge pll_afi_clk) disable iff (reset)
		$fell(cfg_ack) |-> !$past(cfg_req))
		else record_failure("cfg_ack fell while cfg_req high");
	assert property (@(posedge pll_afi_clk) disable iff (reset) $fell(cfg_req) |-> ##2 !cfg_ack)
		else record_failure("cfg_ack late to fall");

endmodule

bind phy_write_top phy_write_sva #(
	.num_write_path_flop_stages (num_write_path_flop_stages)
) sva_inst (
	.pll_afi_clk        (pll_afi_clk),
	.reset              (reset),
	.wr_req             (wr_req),
	.wr_ack             (wr_ack),
	.cfg_req            (cfg_req),
	.cfg_addr           (cfg_addr),
	.cfg_wdata          (cfg_wdata),
	.cfg_ack            (cfg_ack),
	.preamble_en        (preamble_en),
	.force_oct_off      (force_oct_off),
	.phy_ddio_dqs_en    (phy_ddio_dqs_en),
	.phy_ddio_wrdata_en (phy_ddio_wrdata_en),
	.phy_ddio_oct_ena   (phy_ddio_oct_ena)
);

/* test/phy_write_tb.sv */
`timescale 1ns/10ps

module phy_write_tb;

	localparam int stages = 2;
	localparam int wait_limit = 40; // Cycles allowed for one handshake step

	logic pll_afi_clk;
	logic reset;
	logic wr_req;
	logic [phy_write_pkg::afi_data_width-1:0] wr_data;
	logic [phy_write_pkg::afi_data_mask_width-1:0] wr_mask;
	logic wr_ack;
	logic cfg_req;
	logic cfg_addr;
	logic [phy_write_pkg::afi_dqs_width-1:0] cfg_wdata;
	logic cfg_ack;
	logic [phy_write_pkg::afi_data_width-1:0] phy_ddio_dq;
	logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_dqs_en;
	logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_wrdata_en;
	logic [phy_write_pkg::afi_data_mask_width-1:0] phy_ddio_wrdata_mask;
	logic [phy_write_pkg::afi_dqs_width-1:0] phy_ddio_oct_ena;

	logic [phy_write_pkg::afi_data_width-1:0] exp_data [$];
	logic [phy_write_pkg::afi_data_mask_width-1:0] exp_mask [$];
	logic [31:0] rng_state = 32'h936;
	int errors = 0;
	int timeouts = 0;
	int beats_sent = 0;
	int beats_checked = 0;
	int tests_run = 0;
	int mark = 0;

	phy_write_top #(.num_write_path_flop_stages (stages)) dut (.*);

	always #20 pll_afi_clk = ~pll_afi_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic int failure_total();
		return errors + timeouts + dut.sva_inst.fail_count;
	endfunction

	// Lands on the drive point just after the rising edge
	task automatic next_cycle();
		@(posedge pll_afi_clk);
		#2;
	endtask

	task automatic wait_ack(input bit on_cfg, input logic level, input string what);
		int n;
		n = 0;
		while (((on_cfg ? cfg_ack : wr_ack) != level) && n < wait_limit)
		begin
			next_cycle();
			n++;
		end
		if ((on_cfg ? cfg_ack : wr_ack) != level)
		begin
			$display("Timeout at %0t ns: %s never happened", $time, what);
			timeouts++;
		end
	endtask

	task automatic write_beat(input int hold);
		logic [31:0] hi_word;
		wait_ack(1'b0, 1'b0, "wr_ack low before a new beat");
		rng_state = xorshift(rng_state);
		hi_word = rng_state;
		rng_state = xorshift(rng_state);
		wr_data = {hi_word, rng_state};
		rng_state = xorshift(rng_state);
		wr_mask = rng_state[phy_write_pkg::afi_data_mask_width-1:0];
		exp_data.push_back(wr_data);
		exp_mask.push_back(wr_mask);
		beats_sent++;
		wr_req = 1'b1;
		wait_ack(1'b0, 1'b1, "wr_ack for a write beat");
		repeat (hold) next_cycle(); // A held request must not start a second beat
		wr_req = 1'b0;
		wait_ack(1'b0, 1'b0, "wr_ack fall after release");
	endtask

	task automatic config_write(input logic addr, input logic [phy_write_pkg::afi_dqs_width-1:0] data);
		wait_ack(1'b1, 1'b0, "cfg_ack low before a register write");
		cfg_addr = addr;
		cfg_wdata = data;
		cfg_req = 1'b1;
		wait_ack(1'b1, 1'b1, "cfg_ack for a register write");
		repeat (2) next_cycle(); // Ack has to stay up while the request is held
		cfg_req = 1'b0;
		wait_ack(1'b1, 1'b0, "cfg_ack fall after release");
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_data.size() != 0 && n < wait_limit)
		begin
			next_cycle();
			n++;
		end
		if (exp_data.size() != 0)
		begin
			$display("Timeout at %0t ns: %0d beats never reached the DDIO outputs", $time,
				exp_data.size());
			timeouts++;
		end
		repeat (4) next_cycle(); // Termination postamble settles
	endtask

	task automatic finish_test(input string name);
		int n;
		n = failure_total() - mark;
		tests_run++;
		$display("Test %0d %s: %s, %0d errors", tests_run, name, n == 0 ? "ok" : "failed", n);
		mark = failure_total();
	endtask

	// Each write enable pulse on the DDIO side takes the oldest outstanding beat
	always @(negedge pll_afi_clk)
	begin
		if (!reset && phy_ddio_wrdata_en != '0)
		begin
			if (exp_data.size() == 0)
			begin
				$display("Unexpected write beat at %0t ns with no request outstanding", $time);
				errors++;
			end
			else
			begin
				beats_checked++;
				assert (phy_ddio_dq == exp_data[0] && phy_ddio_wrdata_mask == exp_mask[0])
				else
				begin
					$display("Error at %0t ns: beat %h/%h, expected %h/%h", $time, phy_ddio_dq,
						phy_ddio_wrdata_mask, exp_data[0], exp_mask[0]);
					errors++;
				end
				void'(exp_data.pop_front());
				void'(exp_mask.pop_front());
			end
		end
	end

	initial
	begin
		pll_afi_clk = 1'b0;
		reset = 1'b1;
		wr_req = 1'b0;
		wr_data = '0;
		wr_mask = '0;
		cfg_req = 1'b0;
		cfg_addr = 1'b0;
		cfg_wdata = '0;
		repeat (16) @(posedge pll_afi_clk);
		#2;
		reset = 1'b0;
		repeat (20) next_cycle();
		finish_test("idle after reset");

		for (int i = 0; i < 40; i++)
			write_beat(0);
		drain();
		finish_test("random data and mask");

		config_write(phy_write_pkg::cfg_addr_preamble, '0);
		for (int i = 0; i < 8; i++)
			write_beat(0);
		drain();
		config_write(phy_write_pkg::cfg_addr_preamble, '1);
		for (int i = 0; i < 4; i++)
			write_beat(0);
		drain();
		finish_test("preamble off and on");

		for (int m = 0; m < 6; m++)
		begin
			rng_state = xorshift(rng_state);
			config_write(phy_write_pkg::cfg_addr_oct,
				rng_state[phy_write_pkg::afi_dqs_width-1:0]);
			for (int i = 0; i < 3; i++)
				write_beat(0);
			drain();
		end
		config_write(phy_write_pkg::cfg_addr_oct, '0);
		finish_test("termination under force-off masks");

		write_beat(12);
		write_beat(0);
		drain();
		finish_test("handshake with held request");

		if (beats_checked != beats_sent)
		begin
			$display("Only %0d of %0d write beats reached the outputs", beats_checked, beats_sent);
			errors++;
		end
		$display("Tests %0d, beats %0d/%0d, check errors %0d, assertion failures %0d, timeouts %0d",
			tests_run, beats_checked, beats_sent, errors, dut.sva_inst.fail_count, timeouts);
		if (failure_total() == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* sim.f */
logic/phy_write_pkg.sv
logic/phy_write_config.sv
logic/afi_write_sequencer.sv
logic/phy_write_datapath.sv
logic/phy_write_top.sv
test/phy_write_sva.sv
test/phy_write_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the write-path testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module phy_write_tb -o phy_write_sim

# Assertion failures are counted by the bench, so the run continues past them
./obj_dir/phy_write_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	echo "run_sim: pass"
else
	echo "run_sim: fail"
	exit 1
fi
